// ==== logic/sdram_map_defines.svh ====
/*
 * Memory map constants for the arcade SDRAM map.
 * Region starts are byte offsets into the download stream after the header.
 * Include wherever the map or the header layout is needed.
 */
`ifndef SDRAM_MAP_DEFINES_SVH
`define SDRAM_MAP_DEFINES_SVH

// Download regions, offsets after the header
`define BA1_START   25'h00_0800    // Sound ROMs
`define BA2_START   25'h00_0C00    // Graphics ROMs

// Header layout
`define HEADER_LEN  25'd32
`define HDR_DEC     5'h10          // Decryption flags
`define HDR_GAME    5'h18          // Game id

// Work RAM word offset in bank 0
`define RAM_OFFSET  22'h00_1000

`endif

// ==== logic/sdram_map_pkg.sv ====
/*
 * Types shared by the SDRAM map modules.
 * Referenced with scoped names, never imported.
 */
package sdram_map_pkg;

    // Word address into one SDRAM bank
    typedef logic [21:0] sdram_addr_t;

    // Controller data word
    typedef logic [15:0] sdram_word_t;

    // Bank number
    typedef logic [1:0] bank_sel_t;

    // Download byte address
    typedef logic [24:0] ioctl_addr_t;

    // Cached line tag, word address plus one qualifier bit in the LSB
    // (byte select for 8-bit slots, write flag for the RAM slot)
    typedef logic [22:0] slot_key_t;

    // Banks targeted by the downloader
    localparam bank_sel_t BANK_MAIN = 2'd0;
    localparam bank_sel_t BANK_SND  = 2'd1;
    localparam bank_sel_t BANK_GFX  = 2'd2;

endpackage

// ==== logic/bank_req_if.sv ====
/*
 * Request and return lines of one SDRAM bank.
 * Slot modules take the bank modport, the controller side is ctrl.
 */
interface bank_req_if;

    sdram_map_pkg::sdram_addr_t addr;
    logic                       rd;
    logic                       wr;
    sdram_map_pkg::sdram_word_t din;
    logic [1:0]                 wrmask;     // Active low

    logic                       ack;        // Request taken
    logic                       dst;        // First word on data_read
    logic                       rdy;        // Second word, or write done
    sdram_map_pkg::sdram_word_t data_read;

    modport bank (
        output addr, rd, wr, din, wrmask,
        input  ack, dst, rdy, data_read
    );

    modport ctrl (
        input  addr, rd, wr, din, wrmask,
        output ack, dst, rdy, data_read
    );

endinterface

// ==== logic/rom_dwnld.sv ====
/*
 * ROM download into SDRAM.
 * Decodes the 32-byte header, then pairs bytes into words and writes
 * each word to the bank of its region, holding the request until prog_ack.
 * Bytes must be spaced so a word completes before the next pair ends.
 */
`include "sdram_map_defines.svh"

module rom_dwnld (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       downloading,
    input  sdram_map_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]                 ioctl_data,
    input  logic                       ioctl_wr,
    output sdram_map_pkg::sdram_addr_t prog_addr,
    output sdram_map_pkg::sdram_word_t prog_data,
    output logic [1:0]                 prog_mask,
    output sdram_map_pkg::bank_sel_t   prog_ba,
    output logic                       prog_we,
    input  logic                       prog_ack,
    output logic [7:0]                 game_id,
    output logic                       dec_en,
    output logic                       dec_type,
    output logic                       dwnld_busy
);

    localparam sdram_map_pkg::ioctl_addr_t HDR_LEN = `HEADER_LEN;
    localparam sdram_map_pkg::ioctl_addr_t BA1     = `BA1_START;
    localparam sdram_map_pkg::ioctl_addr_t BA2     = `BA2_START;

    logic                       byte_wr, header;
    sdram_map_pkg::ioctl_addr_t offset, rel;
    sdram_map_pkg::bank_sel_t   region;
    logic [7:0]                 low_byte;   // Even byte waiting for its pair

    assign byte_wr    = downloading && ioctl_wr;
    assign header     = ioctl_addr < HDR_LEN;
    assign offset     = ioctl_addr - HDR_LEN;
    assign prog_mask  = 2'b00;              // Both bytes written
    assign dwnld_busy = downloading | prog_we;

    // Region lookup and offset inside it
    always_comb begin
        if (offset < BA1) begin
            region = sdram_map_pkg::BANK_MAIN;
            rel    = offset;
        end else if (offset < BA2) begin
            region = sdram_map_pkg::BANK_SND;
            rel    = offset - BA1;
        end else begin
            region = sdram_map_pkg::BANK_GFX;
            rel    = offset - BA2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            game_id  <= '0;
            dec_en   <= 1'b0;
            dec_type <= 1'b0;
        end else if (byte_wr && header) begin
            if (ioctl_addr[4:0] == `HDR_GAME)
                game_id <= ioctl_data;
            if (ioctl_addr[4:0] == `HDR_DEC) begin
                dec_en   <= |ioctl_data[1:0];
                dec_type <= ioctl_data[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            prog_we <= 1'b0;
        else if (byte_wr && !header && offset[0])
            prog_we <= 1'b1;                // Word complete on the odd byte
        else if (prog_ack)
            prog_we <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (byte_wr && !header) begin
            if (!offset[0]) begin
                low_byte <= ioctl_data;
            end else begin
                prog_data <= {ioctl_data, low_byte};
                prog_addr <= rel[22:1];
                prog_ba   <= region;
            end
        end
    end

    // No byte buffer, so the source must wait for the pending word
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        prog_we && !prog_ack |-> !ioctl_wr)
        else $error("ioctl_wr while a word waits for prog_ack");

endmodule

// ==== logic/rom_slots.sv ====
/*
 * Read-only SDRAM bank shared by two slots of the same payload type.
 * Each slot keeps a one-line cache. Misses go to the controller, slot 0 first.
 * 8-bit slots use byte addresses, 16-bit word addresses, 32-bit pair addresses.
 */
module rom_slots #(
    parameter type                        slot_t  = logic [7:0],
    parameter int                         AW0     = 10,
    parameter int                         AW1     = 10,
    parameter sdram_map_pkg::sdram_addr_t OFFSET1 = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            cs0,
    input  logic [AW0-1:0]  addr0,
    output slot_t           dout0,
    output logic            ok0,
    input  logic            cs1,
    input  logic [AW1-1:0]  addr1,
    output slot_t           dout1,
    output logic            ok1,
    bank_req_if.bank        bus
);

    localparam int DW = $bits(slot_t);

    sdram_map_pkg::slot_key_t   key [2];
    sdram_map_pkg::slot_key_t   tag [2];
    sdram_map_pkg::slot_key_t   req_key;
    slot_t                      cache [2];
    sdram_map_pkg::sdram_word_t first;      // Word taken at dst
    logic [31:0]                fill;
    logic [1:0]                 cs, hit, miss, valid, ok_r;
    logic                       busy, sel, req;

    function automatic sdram_map_pkg::sdram_addr_t word_of(input logic [31:0] a);
        logic [31:0] w;
        if (DW == 8)
            w = a >> 1;
        else if (DW == 16)
            w = a;
        else
            w = a << 1;
        return w[21:0];
    endfunction

    assign key[0] = {word_of(32'(addr0)), DW == 8 ? addr0[0] : 1'b0};
    assign key[1] = {word_of(32'(addr1)) + OFFSET1, DW == 8 ? addr1[0] : 1'b0};
    assign cs     = {cs1, cs0};
    assign miss   = cs & ~hit;

    always_comb begin
        for (int i = 0; i < 2; i++)
            hit[i] = valid[i] && tag[i] == key[i];
    end

    // Line data by payload width
    always_comb begin
        fill = {bus.data_read, first};      // rdy word is the high half
        if (DW == 16)
            fill = {16'd0, first};
        else if (DW == 8)
            fill = {24'd0, req_key[0] ? first[15:8] : first[7:0]};
    end

    assign bus.addr   = req_key[22:1];
    assign bus.rd     = req;
    assign bus.wr     = 1'b0;
    assign bus.din    = '0;
    assign bus.wrmask = 2'b11;

    assign dout0 = cache[0];
    assign dout1 = cache[1];
    assign ok0   = ok_r[0];
    assign ok1   = ok_r[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            req   <= 1'b0;
            sel   <= 1'b0;
            valid <= 2'b00;
            ok_r  <= 2'b00;
        end else begin
            ok_r <= cs & hit;
            if (!busy) begin
                if (miss != 2'b00) begin
                    busy <= 1'b1;
                    req  <= 1'b1;
                    sel  <= ~miss[0];       // Slot 0 wins
                end
            end else begin
                if (bus.ack)
                    req <= 1'b0;
                if (bus.rdy) begin
                    busy       <= 1'b0;
                    valid[sel] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && miss != 2'b00)
            req_key <= miss[0] ? key[0] : key[1];
        if (busy && bus.dst)
            first <= bus.data_read;
        if (busy && bus.rdy) begin
            tag[sel]   <= req_key;
            cache[sel] <= slot_t'(fill[DW-1:0]);
        end
    end

    a_rd_held: assert property (@(posedge clk) disable iff (rst)
        bus.rd && !bus.ack |=> bus.rd && $stable(bus.addr))
        else $error("rd dropped or address moved before ack");

endmodule

// ==== logic/ram_slots.sv ====
/*
 * Bank 0 of the main CPU: work RAM slot with writes, program ROM slot.
 * RAM has priority. A finished write stays reported while the CPU holds
 * cs and the address, and replaces the RAM slot's cached line.
 */
`include "sdram_map_defines.svh"

module ram_slots #(
    parameter int RAW = 10,
    parameter int ROW = 10
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ram_cs,
    input  logic [RAW-1:0]             ram_addr,
    input  logic                       ram_we,
    input  sdram_map_pkg::sdram_word_t ram_din,
    input  logic [1:0]                 ram_mask,   // Active low
    output sdram_map_pkg::sdram_word_t ram_dout,
    output logic                       ram_ok,
    input  logic                       rom_cs,
    input  logic [ROW-1:0]             rom_addr,
    output sdram_map_pkg::sdram_word_t rom_dout,
    output logic                       rom_ok,
    bank_req_if.bank                   bus
);

    sdram_map_pkg::slot_key_t   key [2];
    sdram_map_pkg::slot_key_t   tag [2];
    sdram_map_pkg::slot_key_t   req_key;    // LSB set for a write
    sdram_map_pkg::sdram_word_t cache [2];
    sdram_map_pkg::sdram_word_t wdata;
    logic [1:0]                 wmask;
    logic [1:0]                 cs, hit, miss, valid, ok_r;
    logic                       busy, sel, req, wr_line;

    assign key[0]  = {`RAM_OFFSET + 22'(ram_addr), ram_we};
    assign key[1]  = {22'(rom_addr), 1'b0};
    assign cs      = {rom_cs, ram_cs};
    assign miss    = cs & ~hit;
    assign wr_line = valid[0] && tag[0][0];

    always_comb begin
        for (int i = 0; i < 2; i++)
            hit[i] = valid[i] && tag[i] == key[i];
    end

    assign bus.addr   = req_key[22:1];
    assign bus.rd     = req && !req_key[0];
    assign bus.wr     = req && req_key[0];
    assign bus.din    = wdata;
    assign bus.wrmask = wmask;

    assign ram_dout = cache[0];
    assign rom_dout = cache[1];
    assign ram_ok   = ok_r[0];
    assign rom_ok   = ok_r[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            req   <= 1'b0;
            sel   <= 1'b0;
            valid <= 2'b00;
            ok_r  <= 2'b00;
        end else begin
            ok_r <= cs & hit;
            // Done write forgotten once the CPU moves on
            if (wr_line && !(cs[0] && hit[0]))
                valid[0] <= 1'b0;
            if (!busy) begin
                if (miss != 2'b00) begin
                    busy <= 1'b1;
                    req  <= 1'b1;
                    sel  <= ~miss[0];
                end
            end else begin
                if (bus.ack)
                    req <= 1'b0;
                if (bus.rdy) begin
                    busy       <= 1'b0;
                    valid[sel] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && miss != 2'b00) begin
            req_key <= miss[0] ? key[0] : key[1];
            wdata   <= ram_din;
            wmask   <= ram_mask;
        end
        if (busy && bus.dst && !req_key[0])
            cache[sel] <= bus.data_read;    // 16-bit slots use the first word
        if (busy && bus.rdy)
            tag[sel] <= req_key;
    end

    a_wr_held: assert property (@(posedge clk) disable iff (rst)
        bus.wr && !bus.ack |=> bus.wr && $stable(bus.din))
        else $error("write request changed before ack");

endmodule

// ==== logic/sdram_map.sv ====
/*
 * Memory map of the board core on a four-bank SDRAM controller.
 * Bank 0 main CPU, bank 1 sound, bank 2 graphics, bank 3 unused.
 * The downloader fills the banks before the slots are used.
 */
module sdram_map (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       lvbl,
    input  logic [8:0]                 vrender,

    // Download
    input  logic                       downloading,
    input  sdram_map_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]                 ioctl_data,
    input  logic                       ioctl_wr,
    output logic                       dwnld_busy,
    output logic [7:0]                 game_id,
    output logic                       dec_en,
    output logic                       dec_type,
    output sdram_map_pkg::sdram_addr_t prog_addr,
    output sdram_map_pkg::sdram_word_t prog_data,
    output logic [1:0]                 prog_mask,
    output sdram_map_pkg::bank_sel_t   prog_ba,
    output logic                       prog_we,
    input  logic                       prog_ack,

    // Main CPU, word addresses
    input  logic                       main_cs,
    input  logic                       ram_cs,
    input  logic [9:0]                 main_addr,
    input  logic                       main_rnw,
    input  logic [15:0]                main_dout,
    input  logic [1:0]                 dsn,
    output logic [15:0]                main_data,
    output logic [15:0]                ram_data,
    output logic                       main_ok,
    output logic                       ram_ok,

    // Sound, byte addresses
    input  logic                       snd_cs,
    input  logic [9:0]                 snd_addr,
    output logic [7:0]                 snd_data,
    output logic                       snd_ok,
    input  logic                       pcm_cs,
    input  logic [8:0]                 pcm_addr,
    output logic [7:0]                 pcm_data,
    output logic                       pcm_ok,

    // Graphics, 32-bit addresses
    input  logic [7:0]                 char_addr,
    output logic [31:0]                char_data,
    output logic                       char_ok,
    input  logic [6:0]                 scr_addr,
    output logic [31:0]                scr_data,
    output logic                       scr_ok,

    // SDRAM controller
    output logic [21:0]                ba0_addr,
    output logic [21:0]                ba1_addr,
    output logic [21:0]                ba2_addr,
    output logic [2:0]                 ba_rd,
    output logic                       ba_wr,
    output logic [15:0]                ba0_din,
    output logic [1:0]                 ba0_din_m,
    input  logic [2:0]                 ba_ack,
    input  logic [2:0]                 ba_dst,
    input  logic [2:0]                 ba_rdy,
    input  logic [15:0]                data_read
);

    // Word offsets of the second slot inside banks 1 and 2
    localparam sdram_map_pkg::sdram_addr_t PCM_OFFSET = 22'h100;
    localparam sdram_map_pkg::sdram_addr_t SCR_OFFSET = 22'h100;

    bank_req_if bus [3] ();

    for (genvar i = 0; i < 3; i++) begin : g_bank
        assign bus[i].ack       = ba_ack[i];
        assign bus[i].dst       = ba_dst[i];
        assign bus[i].rdy       = ba_rdy[i];
        assign bus[i].data_read = data_read;
        assign ba_rd[i]         = bus[i].rd;
    end

    assign ba0_addr  = bus[0].addr;
    assign ba1_addr  = bus[1].addr;
    assign ba2_addr  = bus[2].addr;
    assign ba_wr     = bus[0].wr;          // Only bank 0 writes after download
    assign ba0_din   = bus[0].din;
    assign ba0_din_m = bus[0].wrmask;

    rom_dwnld u_dwnld (
        .clk, .rst, .downloading,
        .ioctl_addr, .ioctl_data, .ioctl_wr,
        .prog_addr, .prog_data, .prog_mask, .prog_ba,
        .prog_we, .prog_ack,
        .game_id, .dec_en, .dec_type, .dwnld_busy
    );

    ram_slots #(.RAW(10), .ROW(10)) u_bank0 (
        .clk, .rst,
        .ram_cs   ( ram_cs    ),
        .ram_addr ( main_addr ),
        .ram_we   ( ~main_rnw ),
        .ram_din  ( main_dout ),
        .ram_mask ( dsn       ),
        .ram_dout ( ram_data  ),
        .ram_ok   ( ram_ok    ),
        .rom_cs   ( main_cs   ),
        .rom_addr ( main_addr ),
        .rom_dout ( main_data ),
        .rom_ok   ( main_ok   ),
        .bus      ( bus[0]    )
    );

    rom_slots #(
        .slot_t(logic [7:0]), .AW0(10), .AW1(9), .OFFSET1(PCM_OFFSET)
    ) u_bank1 (
        .clk, .rst,
        .cs0   ( snd_cs   ), .addr0 ( snd_addr ), .dout0 ( snd_data ), .ok0 ( snd_ok ),
        .cs1   ( pcm_cs   ), .addr1 ( pcm_addr ), .dout1 ( pcm_data ), .ok1 ( pcm_ok ),
        .bus   ( bus[1]   )
    );

    // Graphics fetch only in blanking, on line 0 or from line 256
    rom_slots #(
        .slot_t(logic [31:0]), .AW0(8), .AW1(7), .OFFSET1(SCR_OFFSET)
    ) u_bank2 (
        .clk, .rst,
        .cs0   ( !lvbl || vrender == 9'd0 || vrender[8] ),
        .addr0 ( char_addr ), .dout0 ( char_data ), .ok0 ( char_ok ),
        .cs1   ( !lvbl || vrender == 9'd0 || vrender[8] ),
        .addr1 ( scr_addr  ), .dout1 ( scr_data  ), .ok1 ( scr_ok  ),
        .bus   ( bus[2]    )
    );

endmodule

// ==== testbench/tb_clock.sv ====
/*
 * Free-running testbench clock.
 * Instantiate once in the test top and connect clk.
 */
module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;    // 10 ns by default

endmodule

// ==== testbench/sdram_model.sv ====
/*
 * Behavioral four-bank SDRAM controller for the map testbench.
 * Download writes go straight to memory after a short delay.
 * Bank requests are served one at a time: ack, then dst and rdy for
 * a two-word read burst, or rdy alone for a bank 0 write.
 */
module sdram_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [21:0] prog_addr,
    input  logic [15:0] prog_data,
    input  logic [1:0]  prog_mask,
    input  logic [1:0]  prog_ba,
    input  logic        prog_we,
    output logic        prog_ack,
    input  logic [21:0] ba0_addr,
    input  logic [21:0] ba1_addr,
    input  logic [21:0] ba2_addr,
    input  logic [2:0]  ba_rd,
    input  logic        ba_wr,
    input  logic [15:0] ba0_din,
    input  logic [1:0]  ba0_din_m,
    output logic [2:0]  ba_ack,
    output logic [2:0]  ba_dst,
    output logic [2:0]  ba_rdy,
    output logic [15:0] data_read
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] mem [0:3][0:8191];
    logic [21:0] cur_addr;
    logic [1:0]  cur;
    logic        is_wr;
    int          st, cnt, pcnt;

    always @(posedge clk) begin
        if (rst) begin
            prog_ack <= 1'b0;
            ba_ack   <= 3'b0;
            ba_dst   <= 3'b0;
            ba_rdy   <= 3'b0;
            st       <= 0;
            cnt      <= 0;
            pcnt     <= 0;
        end else begin
            // Download port, ack after a few cycles
            prog_ack <= 1'b0;
            if (prog_we && !prog_ack) begin
                if (pcnt == 3) begin
                    if (!prog_mask[0]) mem[prog_ba][prog_addr][7:0] <= prog_data[7:0];
                    if (!prog_mask[1]) mem[prog_ba][prog_addr][15:8] <= prog_data[15:8];
                    prog_ack <= 1'b1;
                    pcnt     <= 0;
                end else begin
                    pcnt <= pcnt + 1;
                end
            end

            ba_ack <= 3'b0;
            ba_dst <= 3'b0;
            ba_rdy <= 3'b0;
            case (st)
                0: begin
                    if (ba_wr || ba_rd != 3'b0) begin
                        is_wr    <= ba_wr;
                        cur      <= ba_wr || ba_rd[0] ? 2'd0 : (ba_rd[1] ? 2'd1 : 2'd2);
                        cur_addr <= ba_wr || ba_rd[0] ? ba0_addr :
                                    (ba_rd[1] ? ba1_addr : ba2_addr);
                        cnt      <= 2;
                        st       <= 1;
                    end
                end
                1: begin
                    if (cnt == 0) begin
                        ba_ack[cur] <= 1'b1;
                        if (is_wr) begin    // Mask is active low
                            if (!ba0_din_m[0]) mem[0][cur_addr][7:0] <= ba0_din[7:0];
                            if (!ba0_din_m[1]) mem[0][cur_addr][15:8] <= ba0_din[15:8];
                        end
                        cnt <= 3;
                        st  <= 2;
                    end else begin
                        cnt <= cnt - 1;
                    end
                end
                2: begin
                    if (cnt == 0) begin
                        if (is_wr) begin
                            ba_rdy[cur] <= 1'b1;
                            st          <= 0;
                        end else begin
                            ba_dst[cur] <= 1'b1;
                            data_read   <= mem[cur][cur_addr];
                            st          <= 3;
                        end
                    end else begin
                        cnt <= cnt - 1;
                    end
                end
                default: begin
                    ba_rdy[cur] <= 1'b1;    // Second burst word
                    data_read   <= mem[cur][cur_addr + 22'd1];
                    st          <= 0;
                end
            endcase
        end
    end

endmodule

// ==== testbench/tb_sdram_map.sv ====
/*
 * Test top for the SDRAM map. Downloads an LCG image with a header,
 * checks the header outputs, then applies a table of client accesses
 * and compares each result with the value rebuilt from the image.
 */
`include "sdram_map_defines.svh"

module tb_sdram_map;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h3919_dc56;
    localparam int HDR    = `HEADER_LEN;
    localparam int BA1    = `BA1_START;
    localparam int BA2    = `BA2_START;
    localparam int DL_LEN = HDR + 'h1000;
    localparam int ROWS   = 15;
    localparam int LIMIT  = ROWS * 200 + DL_LEN * 20;
    localparam int SLOT1_BYTES = 'h200;     // Second slot start in banks 1 and 2
    localparam int P_MAIN = 0, P_HIT = 1, P_SND = 2, P_PCM = 3;
    localparam int P_CHAR = 4, P_SCR = 5, P_RAMW = 6, P_RAMR = 7;

    logic clk, rst, lvbl, downloading, ioctl_wr, dwnld_busy;
    logic [8:0]  vrender;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data, game_id, snd_data, pcm_data;
    logic dec_en, dec_type, prog_we, prog_ack;
    logic [21:0] prog_addr, ba0_addr, ba1_addr, ba2_addr;
    logic [15:0] prog_data, main_dout, main_data, ram_data, ba0_din, data_read;
    logic [1:0]  prog_mask, prog_ba, dsn, ba0_din_m;
    logic main_cs, ram_cs, main_rnw, main_ok, ram_ok, snd_cs, snd_ok, pcm_cs, pcm_ok;
    logic [9:0]  main_addr, snd_addr;
    logic [8:0]  pcm_addr;
    logic [7:0]  char_addr;
    logic [6:0]  scr_addr;
    logic [31:0] char_data, scr_data;
    logic char_ok, scr_ok, ba_wr, rd_prev;
    logic [2:0]  ba_rd, ba_ack, ba_dst, ba_rdy;

    int          row_port [ROWS];
    logic [21:0] row_addr [ROWS];
    logic [15:0] row_wdata [ROWS];
    logic [1:0]  row_mask [ROWS];
    logic [31:0] row_exp [ROWS];
    int          nrows, cycles, rd_pulses, errors;

    tb_clock u_clock (.clk);
    sdram_model u_model (.*);
    sdram_map dut (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // Image byte at any download offset
    function automatic logic [7:0] image_byte(input int off);
        logic [31:0] s;
        s = lcg_next(lcg_next(SEED + 32'(off) * 32'h9e37));
        return s[23:16];
    endfunction

    function automatic logic [31:0] word_at(input int off);
        return {16'd0, image_byte(off + 1), image_byte(off)};
    endfunction

    function automatic logic [31:0] long_at(input int off);
        return {image_byte(off + 3), image_byte(off + 2), image_byte(off + 1), image_byte(off)};
    endfunction

    function automatic logic slot_ok(input int port);
        case (port)
            P_MAIN, P_HIT: return main_ok;
            P_SND:         return snd_ok;
            P_PCM:         return pcm_ok;
            P_CHAR:        return char_ok;
            P_SCR:         return scr_ok;
            default:       return ram_ok;
        endcase
    endfunction

    function automatic logic [31:0] slot_data(input int port);
        case (port)
            P_MAIN, P_HIT: return {16'd0, main_data};
            P_SND:         return {24'd0, snd_data};
            P_PCM:         return {24'd0, pcm_data};
            P_CHAR:        return char_data;
            P_SCR:         return scr_data;
            default:       return {16'd0, ram_data};
        endcase
    endfunction

    function automatic string slot_name(input int port);
        case (port)
            P_MAIN, P_HIT: return "main_data";
            P_SND:         return "snd_data";
            P_PCM:         return "pcm_data";
            P_CHAR:        return "char_data";
            P_SCR:         return "scr_data";
            default:       return "ram_data";
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_row(input int port, input int addr, input logic [15:0] wd,
                           input logic [1:0] mask, input logic [31:0] exp);
        row_port[nrows]  = port;
        row_addr[nrows]  = 22'(addr);
        row_wdata[nrows] = wd;
        row_mask[nrows]  = mask;
        row_exp[nrows]   = exp;
        nrows++;
    endtask

    task automatic fill_table();
        add_row(P_MAIN, 'h005, 0, 0, word_at(HDR + 2 * 'h005));
        add_row(P_HIT,  'h005, 0, 0, word_at(HDR + 2 * 'h005));
        add_row(P_MAIN, 'h3ff, 0, 0, word_at(HDR + 2 * 'h3ff));
        add_row(P_SND,  'h000, 0, 0, image_byte(HDR + BA1));
        add_row(P_SND,  'h3ff, 0, 0, image_byte(HDR + BA1 + 'h3ff));
        add_row(P_PCM,  'h001, 0, 0, image_byte(HDR + BA1 + SLOT1_BYTES + 1));
        add_row(P_PCM,  'h1fe, 0, 0, image_byte(HDR + BA1 + SLOT1_BYTES + 'h1fe));
        add_row(P_CHAR, 'h00,  0, 0, long_at(HDR + BA2));
        add_row(P_CHAR, 'hff,  0, 0, long_at(HDR + BA2 + 4 * 'hff));
        add_row(P_SCR,  'h7f,  0, 0, long_at(HDR + BA2 + SLOT1_BYTES + 4 * 'h7f));
        add_row(P_SCR,  'h10,  0, 0, long_at(HDR + BA2 + SLOT1_BYTES + 4 * 'h10));
        add_row(P_RAMW, 'h020, 16'h1234, 2'b00, 0);
        add_row(P_RAMR, 'h020, 0, 0, 32'h1234);
        add_row(P_RAMW, 'h020, 16'habcd, 2'b10, 0);    // Low byte only
        add_row(P_RAMR, 'h020, 0, 0, 32'h12cd);
    endtask

    task automatic download();
        @(posedge clk);
        downloading <= 1'b1;
        for (int off = 0; off < DL_LEN; off++) begin
            @(posedge clk);
            ioctl_addr <= 25'(off);
            ioctl_data <= image_byte(off);
            ioctl_wr   <= 1'b1;
            @(posedge clk);
            ioctl_wr <= 1'b0;
            repeat (8) @(posedge clk);
        end
        downloading <= 1'b0;
        do @(negedge clk); while (dwnld_busy);
    endtask

    task automatic apply_row(input int r);
        int port;
        int rd_before;
        port = row_port[r];
        rd_before = rd_pulses;
        @(posedge clk);
        main_addr <= 10'(row_addr[r]);
        snd_addr  <= 10'(row_addr[r]);
        pcm_addr  <= 9'(row_addr[r]);
        char_addr <= 8'(row_addr[r]);
        scr_addr  <= 7'(row_addr[r]);
        main_rnw  <= port != P_RAMW;
        main_dout <= row_wdata[r];
        dsn       <= row_mask[r];
        main_cs   <= port == P_MAIN || port == P_HIT;
        ram_cs    <= port == P_RAMW || port == P_RAMR;
        snd_cs    <= port == P_SND;
        pcm_cs    <= port == P_PCM;
        lvbl      <= !(port == P_CHAR || port == P_SCR);
        do @(negedge clk); while (!slot_ok(port));
        if (port != P_RAMW)
            check_val(slot_name(port), slot_data(port), row_exp[r]);
        if (port == P_HIT)
            check_val("ba_rd[0] pulses on hit", rd_pulses - rd_before, 0);
        @(posedge clk);
        {main_cs, ram_cs, snd_cs, pcm_cs} <= 4'b0;
        lvbl <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    // Rising edges of the bank 0 read request
    always @(negedge clk) begin
        if (ba_rd[0] && !rd_prev)
            rd_pulses++;
        rd_prev = ba_rd[0];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    initial begin
        {rst, lvbl, downloading, ioctl_wr} = 4'b1100;
        vrender = 9'd100;                   // Active display line
        ioctl_addr = '0;
        ioctl_data = '0;
        {main_cs, ram_cs, main_rnw, snd_cs, pcm_cs} = 5'b00100;
        {main_addr, snd_addr, pcm_addr, char_addr, scr_addr} = '0;
        main_dout = '0;
        dsn = 2'b11;
        cycles = 0;
        rd_pulses = 0;
        nrows = 0;
        errors = 0;
        rd_prev = 1'b0;
        fill_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        download();
        check_val("game_id", game_id, image_byte(`HDR_GAME));
        check_val("dec_en", dec_en, |(image_byte(`HDR_DEC) & 8'h03));
        check_val("dec_type", dec_type, image_byte(`HDR_DEC) >> 1 & 8'h01);
        // Graphics stay blocked in active display
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            check_val("char_ok", char_ok, 0);
            check_val("scr_ok", scr_ok, 0);
        end
        for (int r = 0; r < nrows; r++)
            apply_row(r);
        if (errors == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== list.f ====
+incdir+logic
logic/sdram_map_pkg.sv
logic/bank_req_if.sv
logic/rom_dwnld.sv
logic/rom_slots.sv
logic/ram_slots.sv
logic/sdram_map.sv
testbench/tb_clock.sv
testbench/sdram_model.sv
testbench/tb_sdram_map.sv

// ==== Bender.yml ====
package:
  name: sdram_map

sources:
  - include_dirs:
      - logic
    files:
      - logic/sdram_map_pkg.sv
      - logic/bank_req_if.sv
      - logic/rom_dwnld.sv
      - logic/rom_slots.sv
      - logic/ram_slots.sv
      - logic/sdram_map.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_clock.sv
      - testbench/sdram_model.sv
      - testbench/tb_sdram_map.sv
